//--- include/fetch_defs.svh
// Fetch subsystem parameters
// Address and instruction widths, BTB depth, memory size and the
// address limits used by the memory model for fault decode

`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Full program counter width
`define FETCH_PC_W 64

// Virtual address width seen by the memory side
`define FETCH_VADDR_W 40

// RV instruction word
`define FETCH_INST_W 32

// Direct-mapped BTB entries, power of two
`define FETCH_BTB_ENTRIES 16

// Instruction memory depth in 32-bit words
`define FETCH_MEM_WORDS 256

// First byte past backed memory, access fault from here
`define FETCH_ACCESS_LIMIT (`FETCH_MEM_WORDS * 4)

// First unmapped byte, page fault from here
`define FETCH_PAGE_LIMIT 'h10000

`endif

//--- design/fetch_pkg.sv
// Fetch subsystem types
// Vector widths, next-PC and exception enums, and the packed structs
// passed between control, fetch stage, predictor and memory

`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

    typedef logic [`FETCH_PC_W-1:0]    addr_pc_t;
    typedef logic [`FETCH_VADDR_W-1:0] vaddr_t;
    typedef logic [`FETCH_INST_W-1:0]  inst_t;

    // Next-PC source picked by control
    typedef enum logic [1:0] {
        NEXT_PC_SEL_KEEP       = 2'd0,
        NEXT_PC_SEL_BP_OR_PC_4 = 2'd1,
        NEXT_PC_SEL_JUMP       = 2'd2
    } next_pc_sel_e;

    // RISC-V mcause codes for fetch
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1,
        INSTR_PAGE_FAULT      = 4'd12
    } xcpt_cause_e;

    typedef enum logic {
        PRED_NOT_TAKEN = 1'b0,
        PRED_TAKEN     = 1'b1
    } pred_decision_e;

    // Prediction carried with the fetched instruction
    typedef struct packed {
        logic           is_branch;
        pred_decision_e decision;
        addr_pc_t       pred_addr;
    } bpred_t;

    typedef struct packed {
        logic        valid;
        xcpt_cause_e cause;
        addr_pc_t    origin;
    } xcpt_t;

    // Packet to decode
    typedef struct packed {
        logic     valid;
        addr_pc_t pc_inst;
        inst_t    inst;
        xcpt_t    ex;
        bpred_t   bpred;
    } fetch_pkt_t;

    typedef struct packed {
        logic   valid;
        vaddr_t vaddr;
    } req_mem_t;

    typedef struct packed {
        logic  valid;
        inst_t data;
        logic  access_fault;
        logic  page_fault;
    } resp_mem_t;

    // Resolved branch from execute
    typedef struct packed {
        logic     valid;
        addr_pc_t pc_execution;
        addr_pc_t target;
        logic     taken;
        logic     is_branch;
    } bp_update_t;

    // Control unit to fetch stage
    typedef struct packed {
        next_pc_sel_e next_pc;
        logic         stall;
    } cu_if_t;

endpackage

`default_nettype wire

//--- design/fetch_control.sv
// Fetch control unit
// Holds fetch off for one cycle after reset, freezes the PC after a
// fetch exception until a redirect, and picks the next-PC source

`default_nettype none

module fetch_control (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              stall_i,
    input  logic              jump_valid_i,
    input  logic              xcpt_seen_i,
    input  logic              fetch_valid_i,
    output fetch_pkg::cu_if_t cu_if_o
);

    logic running_q;
    logic xcpt_hold_q;
    logic xcpt_taken;
    logic stall;

    // Exception packet handed to decode this cycle
    assign xcpt_taken = fetch_valid_i & xcpt_seen_i;

    // Run flop, set on the first edge after reset release
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            running_q <= 1'b0;
        end else begin
            running_q <= 1'b1;
        end
    end

    // Exception hold until the redirect to the handler
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            xcpt_hold_q <= 1'b0;
        end else if (jump_valid_i) begin
            xcpt_hold_q <= 1'b0;
        end else if (xcpt_taken) begin
            xcpt_hold_q <= 1'b1;
        end
    end

    // Stall and next-PC only from flops and inputs, never from the packet
    // Redirect cycle squashes the wrong-path packet
    assign stall = !running_q | jump_valid_i | xcpt_hold_q | stall_i;

    always_comb begin
        cu_if_o.stall = stall;
        if (running_q && jump_valid_i) begin
            // Redirect beats stall and exception hold
            cu_if_o.next_pc = fetch_pkg::NEXT_PC_SEL_JUMP;
        end else if (!stall) begin
            cu_if_o.next_pc = fetch_pkg::NEXT_PC_SEL_BP_OR_PC_4;
        end else begin
            // Stalled PC stays put
            cu_if_o.next_pc = fetch_pkg::NEXT_PC_SEL_KEEP;
        end
    end

endmodule

`default_nettype wire

//--- design/if_stage.sv
// Instruction fetch stage
// PC register with next-PC mux, fetch exception detection and ordering,
// memory request, and assembly of the packet sent to decode

`default_nettype none

`include "fetch_defs.svh"

module if_stage (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  fetch_pkg::addr_pc_t   reset_addr_i,
    input  fetch_pkg::cu_if_t     cu_if_i,
    input  fetch_pkg::addr_pc_t   pc_jump_i,
    input  fetch_pkg::resp_mem_t  resp_mem_i,
    input  logic                  pred_hit_i,
    input  logic                  pred_taken_i,
    input  fetch_pkg::addr_pc_t   pred_addr_i,
    output fetch_pkg::addr_pc_t   pc_fetch_o,
    output fetch_pkg::req_mem_t   req_mem_o,
    output fetch_pkg::fetch_pkt_t fetch_o
);

    fetch_pkg::addr_pc_t pc_q;
    fetch_pkg::addr_pc_t next_pc;

    // Fetch exception sources
    logic xcpt_misaligned;
    logic xcpt_access;
    logic xcpt_page;
    logic xcpt_any;
    logic pred_use;

    // Predicted taken only on a BTB hit
    assign pred_use = pred_hit_i & pred_taken_i;

    // Next-PC mux
    always_comb begin
        case (cu_if_i.next_pc)
            fetch_pkg::NEXT_PC_SEL_KEEP: begin
                next_pc = pc_q;
            end
            fetch_pkg::NEXT_PC_SEL_BP_OR_PC_4: begin
                // Faulting PC stays put behind its exception packet
                if (xcpt_any) begin
                    next_pc = pc_q;
                end else begin
                    next_pc = pred_use ? pred_addr_i : pc_q + 64'd4;
                end
            end
            fetch_pkg::NEXT_PC_SEL_JUMP: begin
                next_pc = pc_jump_i;
            end
            default: begin
                next_pc = pc_q + 64'd4;
            end
        endcase
    end

    // PC register, loads every clock
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= reset_addr_i;
        end else begin
            pc_q <= next_pc;
        end
    end

    assign pc_fetch_o = pc_q;

    // Misaligned checked locally, the rest come back from memory
    assign xcpt_misaligned = |pc_q[1:0];
    assign xcpt_access     = resp_mem_i.valid & resp_mem_i.access_fault;
    assign xcpt_page       = resp_mem_i.valid & resp_mem_i.page_fault;
    assign xcpt_any        = xcpt_misaligned | xcpt_access | xcpt_page;

    // No request for a misaligned PC or while stalled
    assign req_mem_o.valid = !xcpt_misaligned & !cu_if_i.stall;
    assign req_mem_o.vaddr = pc_q[`FETCH_VADDR_W-1:0];

    // Packet to decode
    always_comb begin
        fetch_o.valid   = !cu_if_i.stall && (resp_mem_i.valid || xcpt_any);
        fetch_o.pc_inst = pc_q;
        fetch_o.inst    = resp_mem_i.data;

        // Misaligned > access > page
        fetch_o.ex.origin = pc_q;
        fetch_o.ex.valid  = xcpt_any;
        if (xcpt_misaligned) begin
            fetch_o.ex.cause = fetch_pkg::INSTR_ADDR_MISALIGNED;
        end else if (xcpt_access) begin
            fetch_o.ex.cause = fetch_pkg::INSTR_ACCESS_FAULT;
        end else if (xcpt_page) begin
            fetch_o.ex.cause = fetch_pkg::INSTR_PAGE_FAULT;
        end else begin
            fetch_o.ex.cause = fetch_pkg::INSTR_ADDR_MISALIGNED;
        end

        // Prediction travels on to execute for checking
        fetch_o.bpred.is_branch = pred_hit_i;
        fetch_o.bpred.decision  = pred_use ? fetch_pkg::PRED_TAKEN
                                           : fetch_pkg::PRED_NOT_TAKEN;
        fetch_o.bpred.pred_addr = pred_addr_i;
    end

endmodule

`default_nettype wire

//--- design/branch_predictor.sv
// Branch target buffer
// Direct-mapped table of tags, targets and 2-bit saturating counters,
// read combinationally at fetch and trained by execute

`default_nettype none

`include "fetch_defs.svh"

module branch_predictor (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  fetch_pkg::addr_pc_t   pc_fetch_i,
    input  fetch_pkg::bp_update_t update_i,
    output logic                  hit_o,
    output logic                  taken_o,
    output fetch_pkg::addr_pc_t   target_o
);

    localparam int unsigned IDX_W = $clog2(`FETCH_BTB_ENTRIES);
    localparam int unsigned TAG_W = `FETCH_PC_W - IDX_W - 2;

    typedef logic [IDX_W-1:0] btb_idx_t;
    typedef logic [TAG_W-1:0] btb_tag_t;
    typedef logic [1:0]       ctr_t;

    // Weakly not taken
    localparam ctr_t CTR_INIT = 2'd1;

    logic [`FETCH_BTB_ENTRIES-1:0] valid_q;
    btb_tag_t            tag_q    [`FETCH_BTB_ENTRIES];
    fetch_pkg::addr_pc_t target_q [`FETCH_BTB_ENTRIES];
    ctr_t                ctr_q    [`FETCH_BTB_ENTRIES];

    btb_idx_t rd_idx;
    btb_tag_t rd_tag;
    btb_idx_t upd_idx;
    btb_tag_t upd_tag;
    logic     upd_en;
    logic     upd_match;
    ctr_t     upd_base;
    ctr_t     upd_ctr;

    // Lookup, word index above the byte offset
    assign rd_idx   = pc_fetch_i[IDX_W+1:2];
    assign rd_tag   = pc_fetch_i[`FETCH_PC_W-1:IDX_W+2];
    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign taken_o  = ctr_q[rd_idx][1];
    assign target_o = target_q[rd_idx];

    // Training
    assign upd_en    = update_i.valid & update_i.is_branch;
    assign upd_idx   = update_i.pc_execution[IDX_W+1:2];
    assign upd_tag   = update_i.pc_execution[`FETCH_PC_W-1:IDX_W+2];
    assign upd_match = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

    // New allocation counts from weakly not taken
    always_comb begin
        upd_base = upd_match ? ctr_q[upd_idx] : CTR_INIT;
        if (update_i.taken) begin
            upd_ctr = (upd_base == 2'd3) ? upd_base : upd_base + 2'd1;
        end else begin
            upd_ctr = (upd_base == 2'd0) ? upd_base : upd_base - 2'd1;
        end
    end

    // Valid bits and counters
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
            for (int i = 0; i < `FETCH_BTB_ENTRIES; i++) begin
                ctr_q[i] <= CTR_INIT;
            end
        end else if (upd_en) begin
            valid_q[upd_idx] <= 1'b1;
            ctr_q[upd_idx]   <= upd_ctr;
        end
    end

    // Tag and target payload
    always_ff @(posedge clk_i) begin
        if (upd_en) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= update_i.target;
        end
    end

endmodule

`default_nettype wire

//--- design/inst_mem.sv
// Instruction memory model
// Word array with a synchronous load port and a combinational read,
// standing in for the icache; decodes access and page faults

`default_nettype none

`include "fetch_defs.svh"

module inst_mem (
    input  logic                 clk_i,
    input  fetch_pkg::req_mem_t  req_i,
    output fetch_pkg::resp_mem_t resp_o,
    input  logic                 wr_en_i,
    input  fetch_pkg::vaddr_t    wr_addr_i,
    input  fetch_pkg::inst_t     wr_data_i
);

    localparam int unsigned IDX_W = $clog2(`FETCH_MEM_WORDS);

    // Fault limits at address width
    localparam fetch_pkg::vaddr_t ACCESS_LIMIT = fetch_pkg::vaddr_t'(`FETCH_ACCESS_LIMIT);
    localparam fetch_pkg::vaddr_t PAGE_LIMIT   = fetch_pkg::vaddr_t'(`FETCH_PAGE_LIMIT);

    typedef logic [IDX_W-1:0] mem_idx_t;

    fetch_pkg::inst_t mem_q [`FETCH_MEM_WORDS];

    mem_idx_t rd_idx;
    mem_idx_t wr_idx;
    logic     wr_in_range;
    logic     page_fault;
    logic     access_fault;

    // Word addressing, byte offset dropped
    assign rd_idx = req_i.vaddr[IDX_W+1:2];
    assign wr_idx = wr_addr_i[IDX_W+1:2];

    // Writes outside backed memory are dropped
    assign wr_in_range = wr_addr_i < ACCESS_LIMIT;

    // Same-cycle read returns old data
    always_ff @(posedge clk_i) begin
        if (wr_en_i && wr_in_range) begin
            mem_q[wr_idx] <= wr_data_i;
        end
    end

    // Page limit checked first
    assign page_fault   = req_i.vaddr >= PAGE_LIMIT;
    // Mapped but not backed
    assign access_fault = !page_fault && (req_i.vaddr >= ACCESS_LIMIT);

    // Single-cycle response
    always_comb begin
        resp_o.valid        = req_i.valid;
        resp_o.page_fault   = page_fault;
        resp_o.access_fault = access_fault;
        if (page_fault || access_fault) begin
            // Nothing returned on a fault
            resp_o.data = '0;
        end else begin
            resp_o.data = mem_q[rd_idx];
        end
    end

endmodule

`default_nettype wire

//--- design/fetch_top.sv
// Fetch subsystem top
// Control unit, fetch stage, BTB and instruction memory model

`default_nettype none

module fetch_top (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  fetch_pkg::addr_pc_t   reset_addr_i,
    input  logic                  stall_i,
    input  logic                  jump_valid_i,
    input  fetch_pkg::addr_pc_t   jump_pc_i,
    input  fetch_pkg::bp_update_t bp_update_i,
    input  logic                  mem_wr_en_i,
    input  fetch_pkg::vaddr_t     mem_wr_addr_i,
    input  fetch_pkg::inst_t      mem_wr_data_i,
    output fetch_pkg::fetch_pkt_t fetch_o
);

    fetch_pkg::cu_if_t    cu_if;
    fetch_pkg::req_mem_t  req_mem;
    fetch_pkg::resp_mem_t resp_mem;
    fetch_pkg::addr_pc_t  pc_fetch;
    fetch_pkg::addr_pc_t  pred_addr;
    logic                 pred_hit;
    logic                 pred_taken;

    // Packet valid and exception fed back to control
    fetch_control i_fetch_control (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .stall_i       (stall_i),
        .jump_valid_i  (jump_valid_i),
        .xcpt_seen_i   (fetch_o.ex.valid),
        .fetch_valid_i (fetch_o.valid),
        .cu_if_o       (cu_if)
    );

    if_stage i_if_stage (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .reset_addr_i (reset_addr_i),
        .cu_if_i      (cu_if),
        .pc_jump_i    (jump_pc_i),
        .resp_mem_i   (resp_mem),
        .pred_hit_i   (pred_hit),
        .pred_taken_i (pred_taken),
        .pred_addr_i  (pred_addr),
        .pc_fetch_o   (pc_fetch),
        .req_mem_o    (req_mem),
        .fetch_o      (fetch_o)
    );

    // Trained directly from execute
    branch_predictor i_branch_predictor (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .pc_fetch_i (pc_fetch),
        .update_i   (bp_update_i),
        .hit_o      (pred_hit),
        .taken_o    (pred_taken),
        .target_o   (pred_addr)
    );

    inst_mem i_inst_mem (
        .clk_i     (clk_i),
        .req_i     (req_mem),
        .resp_o    (resp_mem),
        .wr_en_i   (mem_wr_en_i),
        .wr_addr_i (mem_wr_addr_i),
        .wr_data_i (mem_wr_data_i)
    );

endmodule

`default_nettype wire

//--- testbench/fetch_tb.sv
// Fetch subsystem testbench
// Directed tests for sequential fetch, stall, redirect, BTB prediction
// and fetch exceptions, checked against a memory and BTB reference model

`default_nettype none

`include "fetch_defs.svh"

module fetch_tb;

    // Whole run is under 400 cycles
    localparam int          TIMEOUT_CYCLES = 2000;
    localparam logic [63:0] RESET_ADDR     = 64'h0;
    // Branch in BTB slot 0, target in slot 1
    localparam logic [63:0] BR_PC          = 64'h40;
    localparam logic [63:0] BR_TARGET      = 64'h104;

    logic                  clk = 1'b0;
    logic                  rstn;
    fetch_pkg::addr_pc_t   reset_addr;
    logic                  stall;
    logic                  jump_valid;
    fetch_pkg::addr_pc_t   jump_pc;
    fetch_pkg::bp_update_t bp_update;
    logic                  mem_wr_en;
    fetch_pkg::vaddr_t     mem_wr_addr;
    fetch_pkg::inst_t      mem_wr_data;
    fetch_pkg::fetch_pkt_t fetch_pkt;

    // Reference memory
    fetch_pkg::inst_t mem_ref [`FETCH_MEM_WORDS];

    // Reference BTB, 4 index bits above the byte offset
    logic [15:0] btb_valid = '0;
    logic [57:0] btb_tag    [16];
    logic [63:0] btb_target [16];
    logic [1:0]  btb_ctr    [16];

    logic [63:0] exp_pc;
    int          cycle_cnt = 0;

    fetch_top i_fetch_top (
        .clk_i         (clk),
        .rstn_i        (rstn),
        .reset_addr_i  (reset_addr),
        .stall_i       (stall),
        .jump_valid_i  (jump_valid),
        .jump_pc_i     (jump_pc),
        .bp_update_i   (bp_update),
        .mem_wr_en_i   (mem_wr_en),
        .mem_wr_addr_i (mem_wr_addr),
        .mem_wr_data_i (mem_wr_data),
        .fetch_o       (fetch_pkt)
    );

    always #4 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Testbench failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Counter training as execute reports it
    task automatic btb_model_update(input logic [63:0] pc, input logic [63:0] target,
                                    input logic taken);
        logic [3:0] idx;
        logic [1:0] base;
        idx  = pc[5:2];
        base = (btb_valid[idx] && btb_tag[idx] == pc[63:6]) ? btb_ctr[idx] : 2'd1;
        if (taken) begin
            btb_ctr[idx] = (base == 2'd3) ? base : base + 2'd1;
        end else begin
            btb_ctr[idx] = (base == 2'd0) ? base : base - 2'd1;
        end
        btb_valid[idx]  = 1'b1;
        btb_tag[idx]    = pc[63:6];
        btb_target[idx] = target;
    endtask

    // Sampled at the falling edge, away from input changes
    task automatic wait_valid();
        @(negedge clk);
        while (fetch_pkt.valid !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    // Next valid packet against the models, returns the PC that follows it
    task automatic expect_packet(input logic [63:0] pc, output logic [63:0] next_pc);
        logic [3:0] idx;
        logic       hit;
        logic       taken;
        wait_valid();
        idx   = pc[5:2];
        hit   = btb_valid[idx] && (btb_tag[idx] == pc[63:6]);
        taken = hit && (btb_ctr[idx] >= 2'd2);
        check_value("fetch_o.pc_inst", fetch_pkt.pc_inst, pc);
        check_value("fetch_o.inst", 64'(fetch_pkt.inst), 64'(mem_ref[pc[9:2]]));
        check_value("fetch_o.ex.valid", 64'(fetch_pkt.ex.valid), 64'd0);
        check_value("fetch_o.bpred.is_branch", 64'(fetch_pkt.bpred.is_branch), 64'(hit));
        check_value("fetch_o.bpred.decision", 64'(fetch_pkt.bpred.decision),
                    64'(taken ? fetch_pkg::PRED_TAKEN : fetch_pkg::PRED_NOT_TAKEN));
        if (hit) begin
            check_value("fetch_o.bpred.pred_addr", fetch_pkt.bpred.pred_addr,
                        btb_target[idx]);
        end
        next_pc = taken ? btb_target[idx] : pc + 64'd4;
    endtask

    task automatic load_program();
        int i;
        for (i = 0; i < `FETCH_MEM_WORDS; i++) begin
            @(posedge clk);
            mem_ref[i[7:0]] = $urandom();
            mem_wr_en   <= 1'b1;
            mem_wr_addr <= 40'(i * 4);
            mem_wr_data <= mem_ref[i[7:0]];
        end
        @(posedge clk);
        mem_wr_en <= 1'b0;
    endtask

    // One-cycle redirect pulse
    task automatic jump_to(input logic [63:0] addr);
        @(posedge clk);
        jump_valid <= 1'b1;
        jump_pc    <= addr;
        @(posedge clk);
        jump_valid <= 1'b0;
    endtask

    // Back-to-back resolved branches from execute
    task automatic train_branch(input logic [63:0] pc, input logic [63:0] target,
                                input logic taken, input int count);
        repeat (count) begin
            @(posedge clk);
            bp_update.valid        <= 1'b1;
            bp_update.pc_execution <= pc;
            bp_update.target       <= target;
            bp_update.taken        <= taken;
            bp_update.is_branch    <= 1'b1;
            btb_model_update(pc, target, taken);
        end
        @(posedge clk);
        bp_update.valid <= 1'b0;
    endtask

    task automatic expect_fault(input logic [63:0] addr, input fetch_pkg::xcpt_cause_e cause);
        jump_to(addr);
        wait_valid();
        check_value("fetch_o.pc_inst", fetch_pkt.pc_inst, addr);
        check_value("fetch_o.ex.valid", 64'(fetch_pkt.ex.valid), 64'd1);
        check_value("fetch_o.ex.cause", 64'(fetch_pkt.ex.cause), 64'(cause));
        check_value("fetch_o.ex.origin", fetch_pkt.ex.origin, addr);
        // Frozen until the next redirect
        repeat (6) begin
            @(negedge clk);
            check_value("fetch_o.valid", 64'(fetch_pkt.valid), 64'd0);
        end
    endtask

    task automatic test_sequential();
        repeat (8) @(posedge clk);
        @(negedge clk);
        check_value("fetch_o.valid", 64'(fetch_pkt.valid), 64'd0);
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        // Stall kept high while the program goes in
        load_program();
        @(negedge clk);
        check_value("fetch_o.valid", 64'(fetch_pkt.valid), 64'd0);
        check_value("fetch_o.pc_inst", fetch_pkt.pc_inst, RESET_ADDR);
        @(posedge clk);
        stall <= 1'b0;
        exp_pc = RESET_ADDR;
        repeat (20) expect_packet(exp_pc, exp_pc);
    endtask

    task automatic test_stall(input int cycles);
        logic [63:0] held_pc;
        expect_packet(exp_pc, exp_pc);
        held_pc = exp_pc;
        @(posedge clk);
        stall <= 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            check_value("fetch_o.valid", 64'(fetch_pkt.valid), 64'd0);
        end
        @(posedge clk);
        stall <= 1'b0;
        // Held PC comes back first
        expect_packet(held_pc, exp_pc);
        expect_packet(exp_pc, exp_pc);
    endtask

    task automatic test_redirect();
        jump_to(64'h200);
        expect_packet(64'h200, exp_pc);
        repeat (3) expect_packet(exp_pc, exp_pc);
    endtask

    task automatic test_branch();
        // Counter to strongly taken
        train_branch(BR_PC, BR_TARGET, 1'b1, 2);
        jump_to(BR_PC - 64'd8);
        expect_packet(BR_PC - 64'd8, exp_pc);
        expect_packet(BR_PC - 64'd4, exp_pc);
        expect_packet(BR_PC, exp_pc);
        check_value("fetch_o.bpred.is_branch", 64'(fetch_pkt.bpred.is_branch), 64'd1);
        check_value("fetch_o.bpred.decision", 64'(fetch_pkt.bpred.decision),
                    64'(fetch_pkg::PRED_TAKEN));
        check_value("fetch_o.bpred.pred_addr", fetch_pkt.bpred.pred_addr, BR_TARGET);
        expect_packet(BR_TARGET, exp_pc);
        // Back down to weakly not taken
        train_branch(BR_PC, BR_TARGET, 1'b0, 2);
        jump_to(BR_PC - 64'd8);
        expect_packet(BR_PC - 64'd8, exp_pc);
        expect_packet(BR_PC - 64'd4, exp_pc);
        expect_packet(BR_PC, exp_pc);
        check_value("fetch_o.bpred.decision", 64'(fetch_pkt.bpred.decision),
                    64'(fetch_pkg::PRED_NOT_TAKEN));
        expect_packet(BR_PC + 64'd4, exp_pc);
    endtask

    task automatic test_exceptions();
        expect_fault(64'h82, fetch_pkg::INSTR_ADDR_MISALIGNED);
        expect_fault(64'(`FETCH_ACCESS_LIMIT), fetch_pkg::INSTR_ACCESS_FAULT);
        expect_fault(64'(`FETCH_PAGE_LIMIT), fetch_pkg::INSTR_PAGE_FAULT);
        // Misaligned outranks page fault
        expect_fault(64'(`FETCH_PAGE_LIMIT) + 64'h6, fetch_pkg::INSTR_ADDR_MISALIGNED);
        // Recovery through a redirect
        jump_to(64'h20);
        expect_packet(64'h20, exp_pc);
        repeat (3) expect_packet(exp_pc, exp_pc);
    endtask

    initial begin
        void'($urandom(39175));
        rstn        = 1'b0;
        reset_addr  = RESET_ADDR;
        stall       = 1'b1;
        jump_valid  = 1'b0;
        jump_pc     = '0;
        bp_update   = '0;
        mem_wr_en   = 1'b0;
        mem_wr_addr = '0;
        mem_wr_data = '0;
        btb_ctr     = '{default: 2'd1};
        exp_pc      = RESET_ADDR;

        test_sequential();
        test_stall(5);
        test_redirect();
        test_branch();
        test_exceptions();

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
design/fetch_pkg.sv
design/fetch_control.sv
design/if_stage.sv
design/branch_predictor.sv
design/inst_mem.sv
design/fetch_top.sv
testbench/fetch_tb.sv

//--- run.sh
#!/bin/bash
# Build the fetch testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module fetch_tb -f src.f -o fetch_sim \
    && ./obj_dir/fetch_sim > sim.log 2>&1

grep -qx "Testbench passed" sim.log \
    && echo "Simulation PASS" \
    || { echo "Simulation FAIL, see sim.log"; exit 1; }
